// File: bench/cart_loader_assertions.sv
/*
 * Cartridge loader assertions
 * Reset and handshake rules of the download and memory ports,
 * bound into the top level
 */

`default_nettype none
`timescale 1ns/1ps

module cart_loader_assertions (
	input wire                 clk_sys,
	input wire                 arst_n,
	input wire                 dl_wr,
	input wire                 dl_wait,
	input wire                 mem_wr,
	input cart_pkg::mem_addr_t mem_addr
);

	// Control outputs idle straight out of reset
	reset_idle: assert property (@(posedge clk_sys) !arst_n |=> (!dl_wait && !mem_wr))
		else $error("dl_wait or mem_wr active after reset");

	wr_in_stall: assert property (@(posedge clk_sys) disable iff (!arst_n)
		mem_wr |-> dl_wait)
		else $error("mem_wr high without dl_wait");

	// Source must respect the stall
	no_wr_in_stall: assert property (@(posedge clk_sys) disable iff (!arst_n)
		dl_wr |-> !dl_wait)
		else $error("dl_wr while dl_wait high");

	addr_stable: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(dl_wait && $past(dl_wait)) |-> $stable(mem_addr))
		else $error("mem_addr changed during a stall");

endmodule

bind cart_loader cart_loader_assertions cart_loader_assertions_i (
	.clk_sys  (clk_sys),
	.arst_n   (arst_n),
	.dl_wr    (dl_wr),
	.dl_wait  (dl_wait),
	.mem_wr   (mem_wr),
	.mem_addr (mem_addr)
);

`default_nettype wire

// File: bench/cart_loader_tb.sv
/*
 * Cartridge loader testbench
 * Directed tests of the download write path, header probing and
 * ROM bank mapping, against a memory model that stalls at random
 */

`default_nettype none
`timescale 1ns/1ps

module cart_loader_tb;

	import cart_pkg::*;

	logic       clk_sys = 1'b0;
	logic       arst_n, dl_active, dl_cart, dl_wr;
	load_addr_t dl_addr;
	word_t      dl_data, mem_din, cpu_dout;
	logic       dl_wait, mem_wr, cpu_rnw, page_sel_n, region_valid, pier_quirk;
	logic       mem_busy = 1'b0;
	mem_addr_t  mem_addr;
	cpu_addr_t  cpu_va, rom_va, va_mask;
	region_t    region;
	rom_mask_t  rom_mask;

	integer     seed = 84058;
	word_t      mem_model [mem_addr_t]; // Words seen on the memory port
	int         busy_left = 0;
	logic       wr_seen = 1'b0;
	bank_t      bank_exp [8];           // Expected bank registers

	cart_loader #(.NUM_BANKS(8)) cart_loader_i (.*);

	always #5 clk_sys = ~clk_sys;

	////////////////////////////////
	// Memory model
	////////////////////////////////

	// Busy rises one cycle after mem_wr and lasts 1 to 6 cycles
	always @(negedge clk_sys) begin
		if (!arst_n) begin
			mem_busy = 1'b0;
			wr_seen  = 1'b0;
		end else if (mem_busy) begin
			busy_left = busy_left - 1;
			if (busy_left == 0)
				mem_busy = 1'b0;
		end else if (wr_seen) begin
			wr_seen   = 1'b0;
			mem_busy  = 1'b1;
			busy_left = 1 + int'($unsigned($random(seed)) % 6);
		end else if (mem_wr) begin
			mem_model[mem_addr] = mem_din;
			wr_seen = 1'b1;
		end
	end

	////////////////////////////////
	// Helpers
	////////////////////////////////

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			$display("=== FAIL ===");
			$fatal(1, "Check failed");
		end
	endtask

	task automatic set_download(input logic active, input logic cart);
		dl_active = active;
		dl_cart   = cart;
		@(negedge clk_sys);
	endtask

	// One word, then hold off until the write has gone out
	task automatic send_word(input load_addr_t addr, input word_t data);
		int cycles;
		cycles  = 0;
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		while (dl_wait) begin
			@(negedge clk_sys);
			cycles++;
			if (cycles > 40) begin
				$display("Timeout, dl_wait stuck high after a download write");
				$display("=== FAIL ===");
				$fatal(1, "Timeout");
			end
		end
	endtask

	// Header field at 0x180 with the even byte in the low half of each word
	task automatic send_serial(input logic [63:0] id);
		logic [95:0] field;
		logic [7:0]  lo, hi;
		field = {"GM ", id, "-"};
		for (int m = 1; m < 6; m++) begin
			lo = field[95 - 16 * m -: 8];
			hi = field[87 - 16 * m -: 8];
			send_word(HDR_ID_FIRST - 25'd2 + load_addr_t'(2 * m), {hi, lo});
		end
		send_word(HDR_ID_LAST, 16'h3030);
	endtask

	task automatic load_image(input load_addr_t last);
		set_download(1'b1, 1'b1);
		send_word('0, word_t'($random(seed)));
		send_word(last, word_t'($random(seed)));
		set_download(1'b0, 1'b1);
	endtask

	task automatic page_write(input logic [2:0] idx, input word_t data);
		cpu_va     = cpu_addr_t'(idx);
		cpu_dout   = data;
		cpu_rnw    = 1'b0;
		page_sel_n = 1'b0;
		@(negedge clk_sys);
		page_sel_n = 1'b1;
		cpu_rnw    = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic reset_bank_model(input int rom_bytes);
		va_mask = cpu_addr_t'(rom_bytes / 2 - 1); // ROM size in CPU words
		for (int i = 0; i < 8; i++)
			bank_exp[i] = bank_t'(i);
	endtask

	// Random address in every 512 KiB window
	task automatic check_windows(input string what);
		cpu_addr_t va;
		for (int w = 0; w < 8; w++) begin
			va        = cpu_addr_t'($random(seed));
			va[20:18] = 3'(w);
			cpu_va    = va;
			#1;
			check_value(64'(rom_va), 64'({bank_exp[w], va[17:0]} & va_mask), what);
			@(negedge clk_sys);
		end
	endtask

	////////////////////////////////
	// Tests
	////////////////////////////////

	task automatic test_write_path();
		load_addr_t addr;
		word_t      data;
		mem_addr_t  exp_addr;
		for (int c = 1; c >= 0; c--) begin
			set_download(1'b1, c[0]);  // Cartridge first, then BIOS
			for (int n = 0; n < 6; n++) begin
				addr     = load_addr_t'($random(seed)) & ~25'h1;
				data     = word_t'($random(seed));
				exp_addr = c[0] ? mem_addr_t'(addr[22:1])
					: BIOS_BASE + mem_addr_t'(addr[18:1]);
				mem_model.delete(exp_addr);
				send_word(addr, data);
				check_value(64'(mem_model.exists(exp_addr)), 64'd1, "memory write missing");
				check_value(64'(mem_model[exp_addr]), 64'({data[7:0], data[15:8]}),
					"stored word");
			end
			set_download(1'b0, c[0]);
		end
	endtask

	task automatic test_region();
		logic [7:0] letters [3] = '{"J", "U", "E"};
		region_t    codes [3]   = '{REGION_JP, REGION_US, REGION_EU};
		for (int i = 0; i < 3; i++) begin
			set_download(1'b1, 1'b1);
			check_value(64'(region_valid), 64'd0, "region_valid after download start");
			send_word(HDR_REGION_ADDR, {8'h20, letters[i]});
			check_value(64'(region_valid), 64'd1, "region_valid after header");
			check_value(64'(region), 64'(codes[i]), "region code");
			set_download(1'b0, 1'b1);
		end
	endtask

	task automatic test_serial();
		logic [63:0] ids [4]   = '{"T-574023", "T-574013", "T-574033", "T-574023"};
		logic        carts [4] = '{1'b1, 1'b1, 1'b1, 1'b0};
		logic        quirk [4] = '{1'b1, 1'b1, 1'b0, 1'b0};
		for (int i = 0; i < 4; i++) begin
			set_download(1'b1, carts[i]);
			send_serial(ids[i]);
			check_value(64'(pier_quirk), 64'(quirk[i]), "pier_quirk after serial");
			set_download(1'b0, carts[i]);
		end
	endtask

	task automatic test_identity_map();
		load_image(25'hFFFFE);
		check_value(64'(rom_mask), 64'((32'h100000 - 1) >> 13), "1 MiB ROM mask");
		reset_bank_model(32'h100000);
		check_windows("identity map of 1 MiB ROM");
	endtask

	task automatic test_large_banking();
		word_t data [8];
		load_image(25'h7FFFFE); // Reaches byte address bit 22
		reset_bank_model(32'h800000);
		for (int i = 1; i < 8; i++) begin
			data[i] = word_t'($random(seed));
			page_write(3'(i), data[i]);
			bank_exp[i] = data[i][4:0];
		end
		check_windows("large ROM banks");
		set_download(1'b1, 1'b1);
		reset_bank_model(32'h800000); // Identity again while loading
		check_windows("banks during new download");
		send_word('0, 16'h0);
		send_word(25'h3FFFFE, 16'h0); // Exactly 4 MiB is still small
		set_download(1'b0, 1'b1);
		reset_bank_model(32'h400000);
		for (int i = 1; i < 8; i++)
			page_write(3'(i), data[i]);
		check_windows("page writes on small ROM");
	endtask

	task automatic test_pier_banking();
		word_t data;
		set_download(1'b1, 1'b1);
		send_word('0, 16'h0);
		send_serial("T-574013");
		send_word(25'h7FFFFE, 16'h0);
		set_download(1'b0, 1'b1);
		check_value(64'(pier_quirk), 64'd1, "pier_quirk for mapper test");
		reset_bank_model(32'h800000);
		for (int i = 1; i < 5; i++) begin
			data = word_t'($random(seed));
			page_write(3'(i), data);
			if (i < 4)
				bank_exp[i + 4] = bank_t'(data[3:0]); // Index 4 has no bank
		end
		check_windows("special mapper banks");
	endtask

	initial begin
		arst_n     = 1'b0;
		dl_active  = 1'b0;
		dl_cart    = 1'b0;
		dl_wr      = 1'b0;
		dl_addr    = '0;
		dl_data    = '0;
		cpu_va     = '0;
		cpu_dout   = '0;
		cpu_rnw    = 1'b1;
		page_sel_n = 1'b1;
		repeat (3) @(negedge clk_sys);
		arst_n = 1'b1;
		@(negedge clk_sys);

		test_write_path();
		test_region();
		test_serial();
		test_identity_map();
		test_large_banking();
		test_pier_banking();

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: cart_loader.f
rtl/cart_pkg.sv
rtl/cart_probe.sv
rtl/load_writer.sv
rtl/bank_mapper.sv
rtl/cart_loader.sv
bench/cart_loader_assertions.sv
bench/cart_loader_tb.sv

// File: rtl/bank_mapper.sv
/*
 * ROM bank mapper
 * Bank registers written by the CPU through the page-select strobe,
 * used to map CPU ROM addresses into 512 KiB windows, then masked
 * down to the loaded ROM size
 */

`default_nettype none
`timescale 1ns/1ps

module bank_mapper #(
	parameter int NUM_BANKS = cart_pkg::NUM_BANKS
) (
	input  wire                 clk_sys,
	input  wire                 arst_n,
	input  wire                 dl_active,
	input  cart_pkg::cpu_addr_t cpu_va,
	input  cart_pkg::word_t     cpu_dout,
	input  wire                 cpu_rnw,
	input  wire                 page_sel_n,
	input  wire                 pier_quirk,
	input  cart_pkg::rom_mask_t rom_mask,
	output cart_pkg::cpu_addr_t rom_va
);

	import cart_pkg::*;

	localparam int SEL_W = $clog2(NUM_BANKS);

	bank_t            bank_q [NUM_BANKS];
	logic             page_sel_q;
	logic             page_wr;
	logic [SEL_W-1:0] page_idx;
	logic [SEL_W-1:0] pier_idx;
	logic             pier_ok;
	logic             large_rom;
	logic [SEL_W-1:0] va_sel;
	cpu_addr_t        banked_va;

	////////////////////////////////
	// Page write decode
	////////////////////////////////

	// Register index from byte address bits 3..1
	assign page_idx = cpu_va[SEL_W-1:0];

	// Falling edge of the strobe, writes to index 0 are not page writes
	assign page_wr = page_sel_q && !page_sel_n && !cpu_rnw && (page_idx != '0);

	// Special mapper only has banks 5..7, reached through indices 1..3
	assign pier_ok  = (page_idx < SEL_W'(4));
	assign pier_idx = page_idx | SEL_W'(4);

	assign large_rom = |rom_mask[10:9]; // Over 4 MiB

	////////////////////////////////
	// Bank registers
	////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			page_sel_q <= 1'b1;
			for (int i = 0; i < NUM_BANKS; i++)
				bank_q[i] <= bank_t'(i);
		end else begin
			page_sel_q <= page_sel_n;

			if (dl_active) begin
				// Identity map while a new image comes in
				for (int i = 0; i < NUM_BANKS; i++)
					bank_q[i] <= bank_t'(i);
			end else if (page_wr) begin
				if (pier_quirk) begin
					if (pier_ok)
						bank_q[pier_idx] <= bank_t'(cpu_dout[3:0]);
				end else if (large_rom) begin
					bank_q[page_idx] <= cpu_dout[4:0];
				end
			end
		end
	end

	////////////////////////////////
	// Address mapping
	////////////////////////////////

	assign va_sel    = cpu_va[18 +: SEL_W]; // Byte address bits 21..19
	assign banked_va = {bank_q[va_sel], cpu_va[17:0]};

	// Mask covers bits 23..13, everything below always passes
	assign rom_va = banked_va & {rom_mask, 12'hFFF};

endmodule

`default_nettype wire

// File: rtl/cart_loader.sv
/*
 * Cartridge loader top level
 * Download stream feeds the header probe and the memory writer
 * side by side, the probe results steer the ROM bank mapper
 */

`default_nettype none
`timescale 1ns/1ps

module cart_loader #(
	parameter int NUM_BANKS = cart_pkg::NUM_BANKS
) (
	input  wire                  clk_sys,
	input  wire                  arst_n,

	// Download stream
	input  wire                  dl_active,
	input  wire                  dl_cart,   // 1 cartridge, 0 BIOS
	input  wire                  dl_wr,
	input  cart_pkg::load_addr_t dl_addr,
	input  cart_pkg::word_t      dl_data,
	output logic                 dl_wait,

	// External memory
	output cart_pkg::mem_addr_t  mem_addr,
	output cart_pkg::word_t      mem_din,
	output logic                 mem_wr,
	input  wire                  mem_busy,

	// CPU side
	input  cart_pkg::cpu_addr_t  cpu_va,
	input  cart_pkg::word_t      cpu_dout,
	input  wire                  cpu_rnw,
	input  wire                  page_sel_n,
	output cart_pkg::cpu_addr_t  rom_va,

	// Header results
	output cart_pkg::region_t    region,
	output logic                 region_valid,
	output logic                 pier_quirk,
	output cart_pkg::rom_mask_t  rom_mask
);

	////////////////////////////////
	// Download side
	////////////////////////////////

	cart_probe cart_probe_i (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.dl_active    (dl_active),
		.dl_cart      (dl_cart),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.region       (region),
		.region_valid (region_valid),
		.pier_quirk   (pier_quirk),
		.rom_mask     (rom_mask)
	);

	load_writer load_writer_i (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.dl_cart  (dl_cart),
		.dl_wr    (dl_wr),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.mem_busy (mem_busy),
		.dl_wait  (dl_wait),
		.mem_addr (mem_addr),
		.mem_din  (mem_din),
		.mem_wr   (mem_wr)
	);

	////////////////////////////////
	// CPU side
	////////////////////////////////

	bank_mapper #(
		.NUM_BANKS (NUM_BANKS)
	) bank_mapper_i (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dl_active  (dl_active),
		.cpu_va     (cpu_va),
		.cpu_dout   (cpu_dout),
		.cpu_rnw    (cpu_rnw),
		.page_sel_n (page_sel_n),
		.pier_quirk (pier_quirk), // Probe results select the mapper mode
		.rom_mask   (rom_mask),
		.rom_va     (rom_va)
	);

endmodule

`default_nettype wire

// File: rtl/cart_pkg.sv
/*
 * Cartridge loader shared definitions
 * Widths of the download, CPU and memory buses, header addresses
 * of the cartridge image, region codes and the load FSM states
 */

`default_nettype none

package cart_pkg;

	////////////////////////////////
	// Bus widths
	////////////////////////////////

	typedef logic [15:0] word_t;      // Download or CPU data word
	typedef logic [24:0] load_addr_t; // Download byte address
	typedef logic [22:0] cpu_addr_t;  // CPU byte address bits 23..1
	typedef logic [23:0] mem_addr_t;  // External memory word address
	typedef logic [4:0]  bank_t;      // Selects one 512 KiB window
	typedef logic [10:0] rom_mask_t;  // Byte address bits 23..13
	typedef logic [1:0]  region_t;

	localparam region_t REGION_JP = 2'd0;
	localparam region_t REGION_US = 2'd1;
	localparam region_t REGION_EU = 2'd2;

	// Load writer FSM
	typedef enum logic [1:0] {
		LW_IDLE,
		LW_ISSUE,
		LW_DRAIN
	} load_state_t;

	////////////////////////////////
	// Cartridge header layout
	////////////////////////////////

	localparam load_addr_t HDR_REGION_ADDR = 25'h1F0; // First region letter
	localparam load_addr_t HDR_ID_FIRST    = 25'h182;
	localparam load_addr_t HDR_ID_LAST     = 25'h18C; // Serial complete here

	// Serials of the cartridge with its own mapper
	localparam logic [63:0] PIER_ID_A = "T-574023"; // Reprint
	localparam logic [63:0] PIER_ID_B = "T-574013"; // First edition

	// BIOS image sits high in external memory
	localparam mem_addr_t BIOS_BASE = 24'h780000;

	localparam int NUM_BANKS = 8;

endpackage

`default_nettype wire

// File: rtl/cart_probe.sv
/*
 * Cartridge header probe
 * Snoops the download stream for the region letter, the serial
 * number of the special-mapper cartridge and the ROM size mask
 */

`default_nettype none
`timescale 1ns/1ps

module cart_probe (
	input  wire                 clk_sys,
	input  wire                 arst_n,
	input  wire                 dl_active,
	input  wire                 dl_cart,
	input  wire                 dl_wr,
	input  cart_pkg::load_addr_t dl_addr,
	input  cart_pkg::word_t     dl_data,
	output cart_pkg::region_t   region,
	output logic                region_valid,
	output logic                pier_quirk,
	output cart_pkg::rom_mask_t rom_mask
);

	import cart_pkg::*;

	logic        dl_active_q;
	logic        dl_start;
	logic        hdr_wr;
	logic        cart_wr;
	logic        region_hit;
	logic        id_hit;
	logic        id_done;
	load_addr_t  id_off;
	logic [2:0]  id_idx;
	word_t       data_swap;
	logic [63:0] cart_id;

	////////////////////////////////
	// Write decode
	////////////////////////////////

	assign dl_start   = dl_active && !dl_active_q; // New download
	assign hdr_wr     = dl_wr && dl_active;
	assign cart_wr    = hdr_wr && dl_cart;
	assign region_hit = hdr_wr && (dl_addr == HDR_REGION_ADDR);

	// Serial words between 0x182 and 0x18A
	assign id_off  = dl_addr - HDR_ID_FIRST;
	assign id_idx  = id_off[3:1];
	assign id_hit  = cart_wr && (dl_addr >= HDR_ID_FIRST) && (dl_addr < HDR_ID_LAST);
	assign id_done = cart_wr && (dl_addr == HDR_ID_LAST);

	assign data_swap = {dl_data[7:0], dl_data[15:8]};

	////////////////////////////////
	// Header payload capture
	////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (region_hit) begin
			case (dl_data[7:0])
				"J":     region <= REGION_JP;
				"U":     region <= REGION_US;
				default: region <= REGION_EU; // Anything else counts as Europe
			endcase
		end

		// Serial assembled in string order, first letter on top
		if (id_hit) begin
			case (id_idx)
				3'd0:    cart_id[63:56] <= dl_data[15:8];
				3'd1:    cart_id[55:40] <= data_swap;
				3'd2:    cart_id[39:24] <= data_swap;
				3'd3:    cart_id[23:8]  <= data_swap;
				3'd4:    cart_id[7:0]   <= dl_data[7:0];
				default: ;
			endcase
		end
	end

	////////////////////////////////
	// Status flags and size mask
	////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dl_active_q  <= 1'b0;
			region_valid <= 1'b0;
			pier_quirk   <= 1'b0;
			rom_mask     <= '0;
		end else begin
			dl_active_q <= dl_active;

			if (dl_start) begin
				region_valid <= 1'b0;
				pier_quirk   <= 1'b0;
			end

			if (region_hit)
				region_valid <= 1'b1;

			// Compare once the last serial word is in
			if (id_done && (cart_id == PIER_ID_A || cart_id == PIER_ID_B))
				pier_quirk <= 1'b1;

			// Mask grows with the highest address seen
			if (cart_wr) begin
				if (dl_addr == '0)
					rom_mask <= dl_addr[23:13];
				else
					rom_mask <= rom_mask | dl_addr[23:13];
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/load_writer.sv
/*
 * Download word writer
 * Turns each download word into one external memory write and
 * holds the source off with dl_wait until the memory is done
 */

`default_nettype none
`timescale 1ns/1ps

module load_writer (
	input  wire                  clk_sys,
	input  wire                  arst_n,
	input  wire                  dl_cart,
	input  wire                  dl_wr,
	input  cart_pkg::load_addr_t dl_addr,
	input  cart_pkg::word_t      dl_data,
	input  wire                  mem_busy,
	output logic                 dl_wait,
	output cart_pkg::mem_addr_t  mem_addr,
	output cart_pkg::word_t      mem_din,
	output logic                 mem_wr
);

	import cart_pkg::*;

	load_state_t state;
	load_state_t state_nxt;
	logic        accept;

	assign accept = (state == LW_IDLE) && dl_wr;

	////////////////////////////////
	// Write FSM
	////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			LW_IDLE:  if (dl_wr)     state_nxt = LW_ISSUE;
			LW_ISSUE: if (mem_busy)  state_nxt = LW_DRAIN; // Memory took it
			LW_DRAIN: if (!mem_busy) state_nxt = LW_IDLE;
			default:                 state_nxt = LW_IDLE;
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			state <= LW_IDLE;
		else
			state <= state_nxt;
	end

	// Held for the whole write, so longer busy just stretches the stall
	assign dl_wait = (state != LW_IDLE);
	assign mem_wr  = (state == LW_ISSUE);

	////////////////////////////////
	// Address and data latch
	////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			if (dl_cart)
				mem_addr <= {2'b00, dl_addr[22:1]}; // Cartridge ROM area
			else
				mem_addr <= BIOS_BASE + mem_addr_t'(dl_addr[18:1]);
			mem_din <= {dl_data[7:0], dl_data[15:8]}; // Stream is big endian
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the cart_loader testbench with Verilator and run it.
# The exit status is the simulator's: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module cart_loader_tb \
	-f cart_loader.f \
	-Mdir obj_dir -o cart_loader_sim \
	&& ./obj_dir/cart_loader_sim \
	|| exit 1
